//--- digit_feeder.sv
// Start detection, operand capture, step counter and MSD-first digit selection.
`timescale 1ns/1ns

module digit_feeder
  import gf_field_pkg::*;
  import mult_seq_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  gf_elem_t  a,
  input  gf_elem_t  b,
  output gf_elem_t  a_reg,
  output gf_digit_t digit,
  output logic      acc_clear,
  output logic      acc_en,
  output step_t     step,
  output logic      running
);

  gf_operand_u                     b_reg;
  logic [$clog2(NUM_DIGITS)-1:0]   digit_idx;

  // Start seen while idle. This is edge 0 of a new product.
  assign acc_clear = start && !running;

  // Digits are absorbed in steps 1 to 41 only.
  assign acc_en = running && (step >= STEP_FIRST_DIGIT) && (step <= STEP_LAST_DIGIT);

  // Step 1 picks digit 40, step 41 picks digit 0.
  assign digit_idx = STEP_LAST_DIGIT - step;

  assign digit = acc_en ? b_reg.digits[digit_idx] : '0;  // Zero outside the digit steps.

  // Sequence control. Dropping start aborts or ends the sequence.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step    <= '0;
      running <= 1'b0;
    end else if (!start) begin
      step    <= '0;
      running <= 1'b0;
    end else if (!running) begin
      step    <= STEP_FIRST_DIGIT;
      running <= 1'b1;
    end else if (step != STEP_DONE) begin
      step <= step + 1'b1;  // Holds at STEP_DONE until start is released.
    end
  end

  // Operands are taken once, so the caller may change a and b afterwards.
  always_ff @(posedge clk) begin
    if (acc_clear) begin
      a_reg      <= a;
      b_reg.flat <= {{(PAD_W - FIELD_W){1'b0}}, b};  // Pad bit 163 is always zero.
    end
  end

  // The counter must stop at the result step and never wrap past it.
  a_step_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    step <= STEP_DONE
  ) else $error("step counter ran past STEP_DONE");

  // Clearing and absorbing a digit in the same cycle would lose the digit.
  a_clear_en_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(acc_en && acc_clear)
  ) else $error("acc_en and acc_clear high together");

endmodule

//--- digit_mac.sv
// Digit partial product, one-digit shift with reduction, and the accumulator register.
`timescale 1ns/1ns

module digit_mac
  import gf_field_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  gf_elem_t  a_reg,
  input  gf_digit_t digit,
  input  logic      acc_clear,
  input  logic      acc_en,
  output gf_elem_t  acc
);

  localparam int PROD_W = FIELD_W + DIGIT_W - 1;  // Width of a times one digit.
  localparam int WIDE_W = FIELD_W + DIGIT_W;      // Width of the shifted accumulator.

  logic [PROD_W-1:0] pp;
  logic [WIDE_W-1:0] wide;
  gf_elem_t          acc_next;

  // Carry-less product of a with the current digit.
  always_comb begin
    pp = '0;
    for (int i = 0; i < DIGIT_W; i++) begin
      if (digit[i]) begin
        pp = pp ^ (PROD_W'(a_reg) << i);
      end
    end
  end

  // Horner step: acc * x^4 + a * digit, then fold the top bits back.
  // x^163 = x^7 + x^6 + x^3 + 1, so bit 163 + j folds into POLY_TAPS shifted by j.
  // The shifted taps reach bit 10 at most and never overflow again.
  always_comb begin
    wide     = {acc, {DIGIT_W{1'b0}}} ^ WIDE_W'(pp);
    acc_next = wide[FIELD_W-1:0];
    for (int j = 0; j < DIGIT_W; j++) begin
      if (wide[FIELD_W + j]) begin
        acc_next = acc_next ^ (POLY_TAPS << j);
      end
    end
  end

  // Accumulator. Cleared at edge 0 and loaded once per digit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (acc_en) begin
      acc <= acc_next;
    end
  end

  // The feeder only issues digits after capturing a, so acc must be known by then.
  a_acc_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    acc_en |-> !$isunknown(acc)
  ) else $error("accumulator has unknown bits while digits are absorbed");

endmodule

//--- gf_field_pkg.sv
// Field width, digit layout, reduction taps and the operand union for GF(2^163).
package gf_field_pkg;

  // Element width, m = 163.
  localparam int FIELD_W = 163;

  // Width of one digit of b.
  localparam int DIGIT_W = 4;

  // Number of digits per element. The top digit is partial.
  localparam int NUM_DIGITS = 41;

  // Operand width padded up to a whole number of digits.
  localparam int PAD_W = NUM_DIGITS * DIGIT_W;

  // Low terms of x^163 + x^7 + x^6 + x^3 + 1 (bits 7, 6, 3 and 0).
  localparam logic [FIELD_W-1:0] POLY_TAPS = {{(FIELD_W - 8){1'b0}}, 8'b1100_1001};

  // One field element in polynomial basis, bit i is the coefficient of x^i.
  typedef logic [FIELD_W-1:0] gf_elem_t;

  // One digit of the multiplier operand.
  typedef logic [DIGIT_W-1:0] gf_digit_t;

  // The padded operand word, seen either flat or as a digit array.
  // Digit k holds bits 4k+3 down to 4k, so digit 40 carries bits 163..160.
  typedef union packed {
    logic [PAD_W-1:0]            flat;
    gf_digit_t [NUM_DIGITS-1:0]  digits;
  } gf_operand_u;

endpackage

//--- gf_mult_checker.sv
// Testbench checker: bit-serial GF(2^163) model, product, latency, release and abort checks.
`timescale 1ns/1ns

module gf_mult_checker
  import gf_field_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  gf_elem_t a,
  input  gf_elem_t b,
  input  gf_elem_t p,
  input  logic     done,
  output int       tests_done,
  output int       pass_cnt,
  output int       fail_cnt,
  output int       err_cnt
);

  localparam int DONE_EDGE    = 42;  // done rises this many edges after edge 0.
  localparam int ABORT_CYCLES = 60;  // After an abort done must stay low this long.

  bit       reset_checked;
  bit       busy;
  bit       completed;
  bit       release_pending;
  bit       test_err;
  bit       done_prev;
  bit       rise;
  int       cnt;
  int       abort_left;
  int       n_tests;
  int       n_pass;
  int       n_fail;
  int       n_err;
  gf_elem_t exp_p;
  gf_elem_t last_p;

  // Shift-and-add product, MSB of y first, reduced by x^163 + x^7 + x^6 + x^3 + 1.
  function automatic gf_elem_t field_mult_model(input gf_elem_t x, input gf_elem_t y);
    gf_elem_t r;
    logic     carry;
    r = '0;
    for (int i = FIELD_W - 1; i >= 0; i--) begin
      carry = r[FIELD_W-1];
      r = r << 1;
      if (carry) begin  // x^163 folds back into the low terms.
        r[7] = ~r[7];
        r[6] = ~r[6];
        r[3] = ~r[3];
        r[0] = ~r[0];
      end
      if (y[i]) begin
        r = r ^ x;
      end
    end
    return r;
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    n_err++;
    test_err = 1'b1;
  endtask

  task automatic close_test(input string what);
    n_tests++;
    if (test_err) begin
      n_fail++;
      $display("test %0d (%s): FAILED", n_tests, what);
    end else begin
      n_pass++;
      $display("test %0d (%s): passed", n_tests, what);
    end
  endtask

  // Sampled at the rising edge, so outputs show the state after the previous edge.
  always @(posedge clk) begin
    if (!rst_n) begin
      busy            = 1'b0;
      completed       = 1'b0;
      release_pending = 1'b0;
      done_prev       = 1'b0;
      cnt             = 0;
      abort_left      = 0;
      last_p          = '0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        test_err      = 1'b0;
        if (p !== '0) begin
          report_fail($sformatf("p = %h after reset, expected zero", p));
        end
        if (done !== 1'b0) begin
          report_fail("done is not low after reset");
        end
        close_test("reset state");
      end

      if (release_pending) begin  // One edge after start was seen low.
        release_pending = 1'b0;
        if (done !== 1'b0) begin
          report_fail("done still high one edge after start dropped");
        end
        if (p !== last_p) begin
          report_fail($sformatf("p = %h after release, expected %h", p, last_p));
        end
        close_test("product, latency and release");
      end

      if (abort_left > 0) begin
        abort_left--;
        if (abort_left == 0) begin
          if (p !== last_p) begin
            report_fail($sformatf("p = %h after abort, expected %h", p, last_p));
          end
          close_test("abort");
        end
      end

      if (busy && start) begin
        cnt++;
      end
      rise = (done === 1'b1) && !done_prev;
      if (busy && start && cnt == DONE_EDGE + 1) begin
        if (!rise) begin
          report_fail($sformatf("done did not first rise at edge %0d", DONE_EDGE));
        end
        if (p !== exp_p) begin
          report_fail($sformatf("p = %h, expected %h", p, exp_p));
        end
        completed = 1'b1;
        last_p    = exp_p;
      end else if (rise) begin
        report_fail("done rose at an unexpected edge");
      end

      if (busy && !start) begin
        busy = 1'b0;
        if (completed) begin
          release_pending = 1'b1;
        end else begin
          abort_left = ABORT_CYCLES;
        end
      end else if (!busy && start) begin  // Edge 0, the DUT takes a and b here.
        busy      = 1'b1;
        cnt       = 0;
        completed = 1'b0;
        test_err  = 1'b0;
        exp_p     = field_mult_model(a, b);
      end
      done_prev = (done === 1'b1);
    end
    tests_done <= n_tests;
    pass_cnt   <= n_pass;
    fail_cnt   <= n_fail;
    err_cnt    <= n_err;
  end

endmodule

//--- gf_mult_top.sv
// Top level of the GF(2^163) digit-serial multiplier.
`timescale 1ns/1ns

module gf_mult_top
  import gf_field_pkg::*;
  import mult_seq_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  gf_elem_t a,
  input  gf_elem_t b,
  output gf_elem_t p,
  output logic     done
);

  gf_elem_t  a_reg;
  gf_digit_t digit;
  logic      acc_clear;
  logic      acc_en;
  step_t     step;
  logic      running;
  gf_elem_t  acc;

  digit_feeder u_feeder (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .a         (a),
    .b         (b),
    .a_reg     (a_reg),
    .digit     (digit),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .step      (step),
    .running   (running)
  );

  digit_mac u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_reg     (a_reg),
    .digit     (digit),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .acc       (acc)
  );

  result_stage u_result (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .step    (step),
    .running (running),
    .acc     (acc),
    .p       (p),
    .done    (done)
  );

endmodule

//--- list.f
gf_field_pkg.sv
mult_seq_pkg.sv
digit_feeder.sv
digit_mac.sv
result_stage.sv
gf_mult_top.sv
gf_mult_checker.sv
tb_gf_mult.sv

//--- mult_seq_pkg.sv
// Step counter type and the step numbers of the digit-serial multiply sequence.
package mult_seq_pkg;

  // Step counter. It holds 0 while idle and runs up to STEP_DONE.
  typedef logic [5:0] step_t;

  // Step in which the top (partial) digit 40 is issued.
  localparam step_t STEP_FIRST_DIGIT = 6'd1;

  // Step in which digit 0 is issued. The digit index is this value minus the step.
  localparam step_t STEP_LAST_DIGIT = 6'd41;

  // Step in which the accumulator holds the final product and p is written.
  localparam step_t STEP_DONE = 6'd42;

endpackage

//--- result_stage.sv
// Product output register and the done level.
`timescale 1ns/1ns

module result_stage
  import gf_field_pkg::*;
  import mult_seq_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  step_t    step,
  input  logic     running,
  input  gf_elem_t acc,
  output gf_elem_t p,
  output logic     done
);

  logic load;

  // The final digit went in at the previous edge, so acc is complete here.
  assign load = running && (step == STEP_DONE) && !done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p    <= '0;
      done <= 1'b0;
    end else if (!start) begin
      done <= 1'b0;  // p keeps the last product.
    end else if (load) begin
      p    <= acc;
      done <= 1'b1;
    end
  end

  // done rises together with the load of the finished accumulator.
  a_done_with_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(done) |-> (p == acc)
  ) else $error("done rose without p holding the accumulator");

endmodule

//--- run.sh
#!/bin/sh
# Build the GF(2^163) multiplier testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_gf_mult -o tb_gf_mult_sim

if ! ./obj_dir/tb_gf_mult_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi

exit 0

//--- tb_gf_mult.sv
// Testbench top: clock, reset, DUT, seeded random and directed stimulus, and the summary.
`timescale 1ns/1ns

module tb_gf_mult
  import gf_field_pkg::*;
();

  localparam int NUM_RANDOM   = 40;
  localparam int NUM_TESTS    = NUM_RANDOM + 6;  // Reset, 3 directed, abort, one after abort.
  localparam int DONE_TIMEOUT = 100;
  localparam int TEST_TIMEOUT = 100;
  localparam int ABORT_AFTER  = 20;

  logic     clk;
  logic     rst_n;
  logic     start;
  gf_elem_t a;
  gf_elem_t b;
  gf_elem_t p;
  logic     done;
  integer   seed;
  bit       hung;
  int       expected_tests;
  int       tests_done;
  int       pass_cnt;
  int       fail_cnt;
  int       err_cnt;
  gf_elem_t ra;
  gf_elem_t rb;
  gf_elem_t top_bit;

  gf_mult_top u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .a     (a),
    .b     (b),
    .p     (p),
    .done  (done)
  );

  gf_mult_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .a          (a),
    .b          (b),
    .p          (p),
    .done       (done),
    .tests_done (tests_done),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt),
    .err_cnt    (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic random_elem(output gf_elem_t v);
    logic [191:0] w;
    w = {$random(seed), $random(seed), $random(seed),
         $random(seed), $random(seed), $random(seed)};
    v = w[FIELD_W-1:0];
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done !== 1'b1 && n < DONE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (done !== 1'b1) begin
      hung = 1'b1;
      $display("Timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
    end
  endtask

  task automatic sync_tests();
    int n;
    if (!hung) begin
      n = 0;
      while (tests_done < expected_tests && n < TEST_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (tests_done < expected_tests) begin
        hung = 1'b1;
        $display("Timeout: the checker did not finish test %0d within %0d cycles",
                 expected_tests, TEST_TIMEOUT);
      end
    end
  endtask

  task automatic run_product(input gf_elem_t x, input gf_elem_t y);
    gf_elem_t junk;
    if (!hung) begin
      expected_tests++;
      @(posedge clk);
      start <= 1'b1;
      a     <= x;
      b     <= y;
      @(posedge clk);  // Edge 0, operands are captured here.
      random_elem(junk);
      a <= junk;  // The DUT must not look at a and b any more.
      b <= ~junk;
      wait_done();
      start <= 1'b0;
      sync_tests();
    end
  endtask

  task automatic run_abort(input gf_elem_t x, input gf_elem_t y);
    if (!hung) begin
      expected_tests++;
      @(posedge clk);
      start <= 1'b1;
      a     <= x;
      b     <= y;
      repeat (ABORT_AFTER) @(posedge clk);
      start <= 1'b0;
      sync_tests();
    end
  endtask

  initial begin
    seed           = 32'he689_c4c6;
    hung           = 1'b0;
    expected_tests = 0;
    rst_n          = 1'b0;
    start          = 1'b0;
    a              = '0;
    b              = '0;
    top_bit        = '0;
    top_bit[FIELD_W-1] = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    expected_tests = 1;
    sync_tests();
    for (int k = 0; k < NUM_RANDOM; k++) begin
      random_elem(ra);
      random_elem(rb);
      run_product(ra, rb);
    end
    random_elem(rb);
    run_product('0, rb);
    random_elem(rb);
    run_product(gf_elem_t'(1), rb);
    run_product(top_bit, top_bit);  // x^324 needs the full reduction path.
    random_elem(ra);
    random_elem(rb);
    run_abort(ra, rb);
    random_elem(ra);
    random_elem(rb);
    run_product(ra, rb);
    @(negedge clk);
    $display("Summary: %0d tests passed, %0d tests failed, %0d failing checks",
             pass_cnt, fail_cnt, err_cnt);
    if (!hung && fail_cnt == 0 && err_cnt == 0 && pass_cnt == NUM_TESTS) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
